//--- flist.f
+incdir+.
mldsa_pkg.sv
decompose_lane.sv
decompose_rd_ctrl.sv
coeff_credit_fifo.sv
decompose_unit.sv
decompose_top.sv
tb_decompose.sv

//--- run_sim.sh
#!/bin/sh
# Build the decompose testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_decompose -f flist.f \
    || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/Vtb_decompose 2>&1)
echo "$out"
echo "$out" | grep -qxF "Simulation finished: PASS" && exit 0 || exit 1

//--- tb_decompose_tasks.svh
// Address-dependent background so stray reads return recognizable data
task automatic fill_background();
    for (int a = 0; a < MEM_WORDS; a++) begin
        for (int k = 0; k < 4; k++) begin
            coef_mem[a][k*`COEFF_W +: `COEFF_W] = `COEFF_W'(((a * 4 + k) * 8191) % Q);
        end
        hint_mem[a] = {3{32'(a * 32'h9e37 + 7)}};
    end
endtask

task automatic clear_capture();
    for (int a = 0; a < MEM_WORDS; a++) begin
        r0_cap[a]  = '0;
        r0_hits[a] = 0;
        z_cap[a]   = '0;
        z_hits[a]  = 0;
    end
    w1_words.delete();
    done_count = 0;
    coef_reads = 0;
    hint_reads = 0;
    r0_writes  = 0;
    z_writes   = 0;
endtask

// Values around every boundary (2k+1)*GAMMA2, plus 0 and q-1
function automatic int corner_value(input int i);
    int b;
    b = (2 * ((i / 4) % 16) + 1) * GAMMA2;
    case (i % 4)
        0:       corner_value = b - 1;
        1:       corner_value = b;
        2:       corner_value = b + 1;
        default: corner_value = ((i / 4) % 2 == 0) ? 0 : Q - 1;
    endcase
endfunction

task automatic fill_coefs(input int base, input bit corner);
    int r;
    for (int w = 0; w < WORDS; w++) begin
        for (int k = 0; k < 4; k++) begin
            if (corner) begin
                r = corner_value(w * 4 + k);
            end else begin
                r = $urandom % Q;
            end
            coef_mem[base + w][k*`COEFF_W +: `COEFF_W] = `COEFF_W'(r);
        end
    end
endtask

task automatic fill_hints(input int base);
    for (int w = 0; w < WORDS; w++) begin
        hint_mem[base + w] = {$urandom, $urandom, $urandom};
    end
endtask

task automatic run_operation(input dcmp_mode_e m, input int base, input int dest,
                             input int hbase, input int delay);
    @(negedge clk);
    clear_capture();
    credit_delay = delay;
    op_base      = base;
    op_hint_base = hbase;
    @(posedge clk);
    mode_i      <= m;
    base_i      <= `MEM_ADDR_W'(base);
    dest_base_i <= `MEM_ADDR_W'(dest);
    hint_base_i <= `MEM_ADDR_W'(hbase);
    start_i     <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    while (done_count == 0) begin
        @(negedge clk);
    end
    // Let outstanding w1 credits come home before the next operation
    while (busy_o || credit_due.size() != 0) begin
        @(negedge clk);
    end
    repeat (2) @(negedge clk);
    compare_int("done pulses", done_count, 1);
    compare_int("coefficient reads", coef_reads, WORDS);
    compare_int("hint reads", hint_reads, (m == DCMP_VERIFY) ? WORDS : 0);
endtask

task automatic check_results(input dcmp_mode_e m, input int base, input int dest,
                             input int hbase);
    int          r;
    int          r0c;
    int          r1;
    logic [63:0] exp_w1;
    exp_w1 = '0;
    compare_int("w1 word count", w1_words.size(), WORDS / 4);
    compare_int("r0 write count", r0_writes, (m == DCMP_SIGN) ? WORDS : 0);
    compare_int("z write count", z_writes, (m == DCMP_SIGN) ? WORDS : 0);
    for (int w = 0; w < WORDS; w++) begin
        if (m == DCMP_SIGN) begin
            compare_int($sformatf("r0 writes to %0d", dest + w), r0_hits[dest + w], 1);
            compare_int($sformatf("z writes to %0d", w), z_hits[w], 1);
        end
        for (int k = 0; k < 4; k++) begin
            r = int'(coef_mem[base + w][k*`COEFF_W +: `COEFF_W]);
            split_coef(r, r0c, r1);
            if (m == DCMP_SIGN) begin
                compare_int($sformatf("r0 of coefficient %0d", w * 4 + k),
                            int'(r0_cap[dest + w][k*`COEFF_W +: `COEFF_W]),
                            (r0c < 0) ? r0c + Q : r0c);
                compare_int($sformatf("z of coefficient %0d", w * 4 + k),
                            int'(z_cap[w][k]), int'(r1 != 0));
            end else if (hint_mem[hbase + w][k*`COEFF_W]) begin
                r1 = (r0c > 0) ? (r1 + 1) % 16 : (r1 + 15) % 16;
            end
            exp_w1[((w % 4) * 4 + k) * 4 +: 4] = 4'(r1);
        end
        if (w % 4 == 3 && w / 4 < w1_words.size()) begin
            check_count++;
            if (w1_words[w / 4] != exp_w1) begin
                flag_error($sformatf("w1 word %0d is %h, expected %h",
                                     w / 4, w1_words[w / 4], exp_w1));
            end
        end
    end
endtask

task automatic test_reset_values();
    @(negedge clk);
    compare_int("coef_rd_en_o after reset", int'(coef_rd_en_o), 0);
    compare_int("hint_rd_en_o after reset", int'(hint_rd_en_o), 0);
    compare_int("r0_wr_en_o after reset", int'(r0_wr_en_o), 0);
    compare_int("z_wr_en_o after reset", int'(z_wr_en_o), 0);
    compare_int("w1_valid_o after reset", int'(w1_valid_o), 0);
    compare_int("done_o after reset", int'(done_o), 0);
    compare_int("busy_o after reset", int'(busy_o), 0);
endtask

task automatic test_sign_random();
    fill_coefs(0, 1'b0);
    run_operation(DCMP_SIGN, 0, 256, 0, DLY_FAST);
    check_results(DCMP_SIGN, 0, 256, 0);
endtask

task automatic test_corner_values();
    fill_coefs(64, 1'b1);
    run_operation(DCMP_SIGN, 64, 320, 0, DLY_FAST);
    check_results(DCMP_SIGN, 64, 320, 0);
    // Anything past q-1-GAMMA2 must land in r1 = 0
    if (w1_words.size() == WORDS / 4) begin
        for (int i = 0; i < 4 * WORDS; i++) begin
            if (corner_value(i) > Q - 1 - GAMMA2) begin
                compare_int($sformatf("r1 of top coefficient %0d", i),
                            int'(w1_words[i / 16][(i % 16) * 4 +: 4]), 0);
            end
        end
    end
endtask

task automatic test_verify_hints();
    fill_coefs(128, 1'b0);
    fill_hints(640);
    run_operation(DCMP_VERIFY, 128, 512, 640, DLY_FAST);
    check_results(DCMP_VERIFY, 128, 512, 640);
endtask

task automatic test_slow_credits();
    fill_coefs(192, 1'b0);
    run_operation(DCMP_SIGN, 192, 448, 0, DLY_SLOW);
    check_results(DCMP_SIGN, 192, 448, 0);
endtask

//--- tb_decompose.sv
`timescale 1ns/100ps
`include "mldsa_defs.svh"
`default_nettype none

module tb_decompose;
    import mldsa_pkg::*;

    localparam int Q         = `MLDSA_Q;
    localparam int GAMMA2    = `MLDSA_GAMMA2;
    localparam int WORDS     = `POLY_WORDS;
    localparam int MEM_WORDS = 1 << `MEM_ADDR_W;
    localparam int DLY_FAST  = 3;
    localparam int DLY_SLOW  = 40;
    // Three fast-credit tests and one slow one, each 64 words plus a delay per w1 word
    localparam int TEST_LEN_SUM   = 3 * (WORDS + 16 * DLY_FAST) + (WORDS + 16 * DLY_SLOW);
    localparam int TIMEOUT_CYCLES = 5 * TEST_LEN_SUM;

    logic                   clk;
    logic                   reset_n;
    logic                   start_i;
    dcmp_mode_e             mode_i;
    logic [`MEM_ADDR_W-1:0] base_i;
    logic [`MEM_ADDR_W-1:0] dest_base_i;
    logic [`MEM_ADDR_W-1:0] hint_base_i;
    logic                   coef_rd_en_o;
    logic [`MEM_ADDR_W-1:0] coef_rd_addr_o;
    logic [4*`COEFF_W-1:0]  coef_rd_data_i;
    logic                   hint_rd_en_o;
    logic [`MEM_ADDR_W-1:0] hint_rd_addr_o;
    logic [4*`COEFF_W-1:0]  hint_rd_data_i;
    logic                   r0_wr_en_o;
    logic [`MEM_ADDR_W-1:0] r0_wr_addr_o;
    logic [4*`COEFF_W-1:0]  r0_wr_data_o;
    logic                   z_wr_en_o;
    logic [`MEM_ADDR_W-1:0] z_wr_addr_o;
    logic [3:0]             z_o;
    logic                   w1_valid_o;
    logic [63:0]            w1_o;
    logic                   w1_credit_i;
    logic                   busy_o;
    logic                   done_o;

    // Memory model contents and everything the DUT wrote out
    logic [4*`COEFF_W-1:0]  coef_mem [MEM_WORDS];
    logic [4*`COEFF_W-1:0]  hint_mem [MEM_WORDS];
    logic [4*`COEFF_W-1:0]  r0_cap [MEM_WORDS];
    int                     r0_hits [MEM_WORDS];
    logic [3:0]             z_cap [MEM_WORDS];
    int                     z_hits [MEM_WORDS];
    logic [63:0]            w1_words [$];
    int                     credit_due [$];
    int                     cycle_count;
    int                     error_count;
    int                     check_count;
    int                     done_count;
    int                     coef_reads;
    int                     hint_reads;
    int                     r0_writes;
    int                     z_writes;
    int                     op_base;
    int                     op_hint_base;
    int                     credit_delay;
    int                     hash_credits;
    logic                   done_prev;

    always #50 clk = ~clk;

    decompose_top dut_i (.*);

    // Read data comes back one cycle after the enable
    always @(posedge clk) begin
        if (coef_rd_en_o) begin
            coef_rd_data_i <= coef_mem[coef_rd_addr_o];
        end
        if (hint_rd_en_o) begin
            hint_rd_data_i <= hint_mem[hint_rd_addr_o];
        end
    end

    // Read order, write capture and done/busy timing
    always @(posedge clk) begin
        if (reset_n) begin
            if (coef_rd_en_o) begin
                compare_int("coefficient read address", int'(coef_rd_addr_o),
                            op_base + coef_reads);
                coef_reads++;
            end
            if (hint_rd_en_o) begin
                compare_int("hint read address", int'(hint_rd_addr_o), op_hint_base + hint_reads);
                hint_reads++;
            end
            if (r0_wr_en_o) begin
                r0_cap[r0_wr_addr_o] = r0_wr_data_o;
                r0_hits[r0_wr_addr_o]++;
                r0_writes++;
            end
            if (z_wr_en_o) begin
                z_cap[z_wr_addr_o] = z_o;
                z_hits[z_wr_addr_o]++;
                z_writes++;
            end
            if (done_o) begin
                done_count++;
                if (!busy_o) begin
                    flag_error("busy_o low while done_o is high");
                end
            end
            if (done_prev && busy_o) begin
                flag_error("busy_o still high one cycle after done_o");
            end
            done_prev = done_o;
        end
    end

    // Hash side takes every w1 word and hands its credit back credit_delay cycles later
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (w1_valid_o) begin
            if (hash_credits == 0) begin
                flag_error("w1 word sent without a granted credit");
            end
            hash_credits--;
            w1_words.push_back(w1_o);
            credit_due.push_back(cycle_count + credit_delay);
        end
        hash_credits = hash_credits + int'(w1_credit_i);
        if (credit_due.size() != 0 && credit_due[0] <= cycle_count) begin
            w1_credit_i <= 1'b1;
            void'(credit_due.pop_front());
        end else begin
            w1_credit_i <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic flag_error(input string msg);
        error_count++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    task automatic compare_int(input string what, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            flag_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    // Centered remainder mod 2*GAMMA2, with the q-1 corner folded into r1 = 0
    function automatic void split_coef(input int r, output int r0c, output int r1);
        r0c = r % (2 * GAMMA2);
        if (r0c > GAMMA2) begin
            r0c = r0c - 2 * GAMMA2;
        end
        if (r - r0c == Q - 1) begin
            r1  = 0;
            r0c = r0c - 1;
        end else begin
            r1 = (r - r0c) / (2 * GAMMA2);
        end
    endfunction

    `include "tb_decompose_tasks.svh"

    initial begin
        void'($urandom(32'h48a2_dc2e));
        clk            = 1'b0;
        reset_n        = 1'b0;
        start_i        = 1'b0;
        mode_i         = DCMP_SIGN;
        base_i         = '0;
        dest_base_i    = '0;
        hint_base_i    = '0;
        coef_rd_data_i = '0;
        hint_rd_data_i = '0;
        w1_credit_i    = 1'b0;
        cycle_count    = 0;
        error_count    = 0;
        check_count    = 0;
        hash_credits   = `W1_CREDITS;
        credit_delay   = DLY_FAST;
        done_prev      = 1'b0;
        fill_background();
        clear_capture();
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_values();
        test_sign_random();
        test_corner_values();
        test_verify_hints();
        test_slow_credits();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- decompose_top.sv
`timescale 1ns/100ps
`include "mldsa_defs.svh"
`default_nettype none

module decompose_top (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     start_i,
    input  mldsa_pkg::dcmp_mode_e   mode_i,
    input  wire  [`MEM_ADDR_W-1:0]  base_i,
    input  wire  [`MEM_ADDR_W-1:0]  dest_base_i,
    input  wire  [`MEM_ADDR_W-1:0]  hint_base_i,
    // Coefficient and hint memory read ports
    output logic                    coef_rd_en_o,
    output logic [`MEM_ADDR_W-1:0]  coef_rd_addr_o,
    input  wire  [4*`COEFF_W-1:0]   coef_rd_data_i,
    output logic                    hint_rd_en_o,
    output logic [`MEM_ADDR_W-1:0]  hint_rd_addr_o,
    input  wire  [4*`COEFF_W-1:0]   hint_rd_data_i,
    // r0 write-back
    output logic                    r0_wr_en_o,
    output logic [`MEM_ADDR_W-1:0]  r0_wr_addr_o,
    output logic [4*`COEFF_W-1:0]   r0_wr_data_o,
    // z buffer
    output logic                    z_wr_en_o,
    output logic [`MEM_ADDR_W-1:0]  z_wr_addr_o,
    output logic [3:0]              z_o,
    // Hash side
    output logic                    w1_valid_o,
    output logic [63:0]             w1_o,
    input  wire                     w1_credit_i,
    output logic                    busy_o,
    output logic                    done_o
);

    logic                   push;
    logic [4*`COEFF_W-1:0]  push_coef;
    logic [3:0]             push_hint;
    logic                   credit_return;
    logic                   pop;
    logic [4*`COEFF_W-1:0]  head_coef;
    logic [3:0]             head_hint;
    logic                   not_empty;

    decompose_rd_ctrl u_rd_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_i         (start_i),
        .mode_i          (mode_i),
        .base_i          (base_i),
        .hint_base_i     (hint_base_i),
        .coef_rd_en_o    (coef_rd_en_o),
        .coef_rd_addr_o  (coef_rd_addr_o),
        .hint_rd_en_o    (hint_rd_en_o),
        .hint_rd_addr_o  (hint_rd_addr_o),
        .coef_rd_data_i  (coef_rd_data_i),
        .hint_rd_data_i  (hint_rd_data_i),
        .credit_return_i (credit_return),
        .push_o          (push),
        .push_coef_o     (push_coef),
        .push_hint_o     (push_hint),
        .done_i          (done_o),
        .busy_o          (busy_o)
    );

    coeff_credit_fifo u_fifo (
        .clk             (clk),
        .reset_n         (reset_n),
        .push_i          (push),
        .push_coef_i     (push_coef),
        .push_hint_i     (push_hint),
        .pop_i           (pop),
        .head_coef_o     (head_coef),
        .head_hint_o     (head_hint),
        .not_empty_o     (not_empty),
        .credit_return_o (credit_return)
    );

    decompose_unit u_unit (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .dest_base_i  (dest_base_i),
        .head_coef_i  (head_coef),
        .head_hint_i  (head_hint),
        .not_empty_i  (not_empty),
        .pop_o        (pop),
        .r0_wr_en_o   (r0_wr_en_o),
        .r0_wr_addr_o (r0_wr_addr_o),
        .r0_wr_data_o (r0_wr_data_o),
        .z_wr_en_o    (z_wr_en_o),
        .z_wr_addr_o  (z_wr_addr_o),
        .z_o          (z_o),
        .w1_valid_o   (w1_valid_o),
        .w1_o         (w1_o),
        .w1_credit_i  (w1_credit_i),
        .done_o       (done_o)
    );

endmodule

`default_nettype wire

//--- decompose_unit.sv
`timescale 1ns/100ps
`include "mldsa_defs.svh"
`default_nettype none

module decompose_unit (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     start_i,
    input  mldsa_pkg::dcmp_mode_e   mode_i,
    input  wire  [`MEM_ADDR_W-1:0]  dest_base_i,
    input  wire  [4*`COEFF_W-1:0]   head_coef_i,
    input  wire  [3:0]              head_hint_i,
    input  wire                     not_empty_i,
    output logic                    pop_o,
    output logic                    r0_wr_en_o,
    output logic [`MEM_ADDR_W-1:0]  r0_wr_addr_o,
    output logic [4*`COEFF_W-1:0]   r0_wr_data_o,
    output logic                    z_wr_en_o,
    output logic [`MEM_ADDR_W-1:0]  z_wr_addr_o,
    output logic [3:0]              z_o,
    output logic                    w1_valid_o,
    output logic [63:0]             w1_o,
    input  wire                     w1_credit_i,
    output logic                    done_o
);
    import mldsa_pkg::*;

    localparam int IDX_W = $clog2(`POLY_WORDS);
    localparam int CNT_W = $clog2(`POLY_WORDS + 1);
    localparam int W1C_W = $clog2(`W1_CREDITS + 1);

    unit_state_e        state_q;
    logic [CNT_W-1:0]   pop_cnt_q;
    logic [W1C_W-1:0]   w1_cnt_q;
    logic [W1C_W-1:0]   resv_q;
    logic               s1_valid_q;
    logic [IDX_W-1:0]   s1_idx_q;
    logic               verify;
    logic               grp_first;
    logic               reserve;
    logic               last_out;
    logic [4*`COEFF_W-1:0] r0_pack;
    logic [22:0]        lane_r0 [4];
    logic [3:0]         lane_r1 [4];
    logic [3:0]         lane_z;

    assign verify    = (mode_i == DCMP_VERIFY);
    assign grp_first = (pop_cnt_q[1:0] == 2'd0);

    // First word of a group needs a free w1 slot before it enters the pipe
    assign pop_o = (state_q == UNIT_RUN) && not_empty_i
                   && (pop_cnt_q != CNT_W'(`POLY_WORDS))
                   && (!grp_first || (w1_cnt_q != '0));
    assign reserve  = pop_o && grp_first;
    assign last_out = s1_valid_q && (s1_idx_q == IDX_W'(`POLY_WORDS - 1));

    for (genvar i = 0; i < 4; i++) begin : g_lane
        decompose_lane u_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .en_i     (pop_o),
            .verify_i (verify),
            .r_i      (head_coef_i[i*`COEFF_W +: 23]),
            .hint_i   (head_hint_i[i]),
            .r0_o     (lane_r0[i]),
            .r1_o     (lane_r1[i]),
            .z_o      (lane_z[i])
        );
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            r0_pack[i*`COEFF_W +: `COEFF_W] = `COEFF_W'(lane_r0[i]);
        end
    end

    // Control and pipeline valid
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= UNIT_IDLE;
            pop_cnt_q  <= '0;
            w1_cnt_q   <= W1C_W'(`W1_CREDITS);
            resv_q     <= '0;
            s1_valid_q <= 1'b0;
            r0_wr_en_o <= 1'b0;
            z_wr_en_o  <= 1'b0;
            w1_valid_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            case (state_q)
                UNIT_IDLE: if (start_i) state_q <= UNIT_RUN;
                UNIT_RUN:  if (last_out) state_q <= UNIT_IDLE;
                default:   state_q <= UNIT_IDLE;
            endcase
            if (start_i && (state_q == UNIT_IDLE)) begin
                pop_cnt_q <= '0;
            end else if (pop_o) begin
                pop_cnt_q <= pop_cnt_q + 1'b1;
            end
            w1_cnt_q   <= w1_cnt_q - W1C_W'(reserve) + W1C_W'(w1_credit_i);
            resv_q     <= resv_q + W1C_W'(reserve) - W1C_W'(w1_valid_o);
            s1_valid_q <= pop_o;
            r0_wr_en_o <= s1_valid_q && !verify;
            z_wr_en_o  <= s1_valid_q && !verify;
            w1_valid_o <= s1_valid_q && (s1_idx_q[1:0] == 2'd3);
            done_o     <= last_out;
        end
    end

    // Word index and output payload
    always_ff @(posedge clk) begin
        if (pop_o) begin
            s1_idx_q <= pop_cnt_q[IDX_W-1:0];
        end
        if (s1_valid_q) begin
            r0_wr_addr_o <= dest_base_i + `MEM_ADDR_W'(s1_idx_q);
            r0_wr_data_o <= r0_pack;
            z_wr_addr_o  <= `MEM_ADDR_W'(s1_idx_q);
            z_o          <= lane_z;
            // First coefficient ends up in the low bits after four shifts
            w1_o <= {lane_r1[3], lane_r1[2], lane_r1[1], lane_r1[0], w1_o[63:16]};
        end
    end

    // Every w1 word must own a slot reserved when its group started
    w1_reserved_a: assert property (@(posedge clk) disable iff (!reset_n)
        w1_valid_o |-> (resv_q != '0));

endmodule

`default_nettype wire

//--- coeff_credit_fifo.sv
`timescale 1ns/100ps
`include "mldsa_defs.svh"
`default_nettype none

module coeff_credit_fifo (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     push_i,
    input  wire  [4*`COEFF_W-1:0]   push_coef_i,
    input  wire  [3:0]              push_hint_i,
    input  wire                     pop_i,
    output logic [4*`COEFF_W-1:0]   head_coef_o,
    output logic [3:0]              head_hint_o,
    output logic                    not_empty_o,
    output logic                    credit_return_o
);

    localparam int ENTRY_W = 4 * `COEFF_W + 4;
    localparam int PTR_W   = $clog2(`FIFO_DEPTH);
    localparam int CNT_W   = $clog2(`FIFO_DEPTH + 1);

    logic [ENTRY_W-1:0] mem_q [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_pop;

    assign not_empty_o = (count_q != '0);
    assign do_pop      = pop_i && not_empty_o;

    // Each consumed entry frees one slot for the producer right away
    assign credit_return_o = do_pop;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= {push_hint_i, push_coef_i};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
        end
    end

    // Show-ahead head
    assign head_coef_o = mem_q[rd_ptr_q][4*`COEFF_W-1:0];
    assign head_hint_o = mem_q[rd_ptr_q][ENTRY_W-1 -: 4];

    // Producer credits must keep the buffer from overflowing
    no_overflow_a: assert property (@(posedge clk) disable iff (!reset_n)
        push_i |-> (count_q != CNT_W'(`FIFO_DEPTH)));

    // Consumer only pops what is there
    no_underflow_a: assert property (@(posedge clk) disable iff (!reset_n)
        pop_i |-> not_empty_o);

endmodule

`default_nettype wire

//--- decompose_rd_ctrl.sv
`timescale 1ns/100ps
`include "mldsa_defs.svh"
`default_nettype none

module decompose_rd_ctrl (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         start_i,
    input  mldsa_pkg::dcmp_mode_e       mode_i,
    input  wire  [`MEM_ADDR_W-1:0]      base_i,
    input  wire  [`MEM_ADDR_W-1:0]      hint_base_i,
    output logic                        coef_rd_en_o,
    output logic [`MEM_ADDR_W-1:0]      coef_rd_addr_o,
    output logic                        hint_rd_en_o,
    output logic [`MEM_ADDR_W-1:0]      hint_rd_addr_o,
    input  wire  [4*`COEFF_W-1:0]       coef_rd_data_i,
    input  wire  [4*`COEFF_W-1:0]       hint_rd_data_i,
    input  wire                         credit_return_i,
    output logic                        push_o,
    output logic [4*`COEFF_W-1:0]       push_coef_o,
    output logic [3:0]                  push_hint_o,
    input  wire                         done_i,
    output logic                        busy_o
);
    import mldsa_pkg::*;

    localparam int IDX_W = $clog2(`POLY_WORDS);
    localparam int CRD_W = $clog2(`FIFO_DEPTH + 1);

    rd_state_e          state_q, state_d;
    logic [IDX_W-1:0]   rd_idx_q;
    logic [CRD_W-1:0]   credit_q;
    logic               issue;
    logic               verify;

    assign verify = (mode_i == DCMP_VERIFY);

    // One read per cycle while a buffer slot is guaranteed
    assign issue = (state_q == RD_ISSUE) && (credit_q != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE:  if (start_i) state_d = RD_ISSUE;
            RD_ISSUE: if (issue && (rd_idx_q == IDX_W'(`POLY_WORDS - 1))) state_d = RD_DRAIN;
            RD_DRAIN: if (done_i) state_d = RD_IDLE;
            default:  state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= RD_IDLE;
            rd_idx_q <= '0;
            credit_q <= CRD_W'(`FIFO_DEPTH);
            push_o   <= 1'b0;
        end else begin
            state_q  <= state_d;
            credit_q <= credit_q - CRD_W'(issue) + CRD_W'(credit_return_i);
            push_o   <= issue;
            if (start_i && (state_q == RD_IDLE)) begin
                rd_idx_q <= '0;
            end else if (issue) begin
                rd_idx_q <= rd_idx_q + 1'b1;
            end
        end
    end

    assign coef_rd_en_o   = issue;
    assign coef_rd_addr_o = base_i + `MEM_ADDR_W'(rd_idx_q);
    assign hint_rd_en_o   = issue && verify;
    assign hint_rd_addr_o = hint_base_i + `MEM_ADDR_W'(rd_idx_q);

    // Read data arrives one cycle after the enable and goes straight into the buffer
    assign push_coef_o = coef_rd_data_i;

    // Hint bit k is the LSB of field k
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            push_hint_o[k] = verify & hint_rd_data_i[k*`COEFF_W];
        end
    end

    assign busy_o = (state_q != RD_IDLE);

    // Returned credits can never exceed what was handed out
    credit_bound_a: assert property (@(posedge clk) disable iff (!reset_n)
        credit_q <= CRD_W'(`FIFO_DEPTH));

endmodule

`default_nettype wire

//--- decompose_lane.sv
`timescale 1ns/100ps
`include "mldsa_defs.svh"
`default_nettype none

module decompose_lane (
    input  wire         clk,
    input  wire         reset_n,
    input  wire         en_i,
    input  wire         verify_i,
    input  wire  [22:0] r_i,
    input  wire         hint_i,
    output logic [22:0] r0_o,
    output logic [3:0]  r1_o,
    output logic        z_o
);

    localparam logic [22:0] GAMMA2     = 23'(`MLDSA_GAMMA2);
    localparam logic [22:0] TWO_GAMMA2 = 23'(2 * `MLDSA_GAMMA2);
    localparam logic [24:0] Q_EXT      = 25'(`MLDSA_Q);

    logic [15:0] above;
    logic        corner;
    logic [3:0]  r1_raw;
    logic [3:0]  r1_c;
    logic [22:0] r1_prod;
    logic [24:0] r0_diff;
    logic        r0_neg;
    logic        r0_pos;
    logic [22:0] r0_modq;
    logic [3:0]  r1_hinted;

    // Thermometer compare against the boundaries (2k+1)*GAMMA2
    always_comb begin
        for (int k = 0; k < 16; k++) begin
            above[k] = (r_i > 23'((2 * k + 1) * GAMMA2));
        end
    end

    // Top boundary is q-1-GAMMA2, past it r-r0 would be q-1
    assign corner = above[15];

    always_comb begin
        r1_raw = '0;
        for (int k = 0; k < 15; k++) begin
            r1_raw = r1_raw + 4'(above[k]);
        end
    end

    assign r1_c = corner ? 4'd0 : r1_raw;

    // Centered remainder, range (-GAMMA2, GAMMA2]
    assign r1_prod = TWO_GAMMA2 * {19'd0, r1_c};
    assign r0_diff = {2'b00, r_i} - {2'b00, r1_prod};
    assign r0_neg  = r0_diff[24];

    // Corner case r0 = r - q, which is r again modulo q
    always_comb begin
        if (corner) begin
            r0_modq = r_i;
        end else if (r0_neg) begin
            r0_modq = 23'(r0_diff + Q_EXT);
        end else begin
            r0_modq = r0_diff[22:0];
        end
    end

    // Corner r0 is never positive
    assign r0_pos = !corner && !r0_neg && (r0_diff != '0);

    // Use-hint step wraps modulo 16
    assign r1_hinted = r0_pos ? r1_c + 4'd1 : r1_c - 4'd1;

    always_ff @(posedge clk) begin
        if (en_i) begin
            r0_o <= r0_modq;
            z_o  <= (r1_c != 4'd0);
            r1_o <= (verify_i && hint_i) ? r1_hinted : r1_c;
        end
    end

    // Corner coefficients have passed every lower boundary, so the plain count would reach 16
    corner_thermo_a: assert property (@(posedge clk) disable iff (!reset_n)
        (en_i && corner) |-> (&above[14:0]));

endmodule

`default_nettype wire

//--- mldsa_pkg.sv
`default_nettype none

package mldsa_pkg;

    // Operation mode of the decompose subsystem
    typedef enum logic {
        DCMP_SIGN   = 1'b0,
        DCMP_VERIFY = 1'b1
    } dcmp_mode_e;

    // Read controller states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        // All reads issued, wait for the datapath to finish
        RD_DRAIN
    } rd_state_e;

    // Datapath states
    typedef enum logic {
        UNIT_IDLE,
        UNIT_RUN
    } unit_state_e;

endpackage

`default_nettype wire

//--- mldsa_defs.svh
`ifndef MLDSA_DEFS_SVH
`define MLDSA_DEFS_SVH

// ML-DSA modulus q
`define MLDSA_Q 23'd8380417

// (q-1)/32, so r1 stays within 4 bits
`define MLDSA_GAMMA2 261888

// Coefficient field width inside a memory word, top bit always zero
`define COEFF_W 24

// Memory word address width
`define MEM_ADDR_W 10

// Four coefficients per word, 256 per polynomial
`define POLY_WORDS 64

// Buffer entries, also the producer's starting credit count
`define FIFO_DEPTH 4

// w1 slots the hash side grants after reset
`define W1_CREDITS 2

`endif
